// File: filelist.f
verilog/layers_pkg.sv
verilog/group_mac.sv
verilog/group_add.sv
verilog/pool.sv
verilog/rectify_rescale.sv
verilog/layer_ctrl.sv
verilog/layers.sv
bench/layers_props.sv
bench/layers_tb.sv

// File: Makefile
# Verilator build and run of the layers testbench

SRCS := $(wildcard verilog/*.sv) $(wildcard bench/*.sv)

obj_dir/Vlayers_tb: filelist.f $(SRCS)
	verilator --binary --assert -Wno-fatal --top-module layers_tb -f filelist.f

run: obj_dir/Vlayers_tb
	./obj_dir/Vlayers_tb

clean:
	rm -rf obj_dir

.PHONY: run clean

// File: bench/layers_tb.sv
/*
 * Directed testbench for the layers stage, 4 lanes of 4 groups.
 * Frame sums stay far below the accumulator range, so nothing wraps.
 * The configuration is only rewritten with no frame in flight.
 */
`timescale 1ns/1ps

module layers_tb;

    import layers_pkg::*;

    localparam int DEPTH_NB       = 4;
    localparam int GROUP_NB       = 4;
    localparam int FRAMES_SENT    = 13;
    localparam int TIMEOUT_CYCLES = FRAMES_SENT * 200 + 100;
    localparam longint PIX_MAX    = 2 ** (IMG_WIDTH - 1) - 1;
    localparam longint PIX_MIN    = -(2 ** (IMG_WIDTH - 1));

    typedef struct packed {
        img_t [GROUP_NB-1:0]               img;
        ker_t [DEPTH_NB-1:0][GROUP_NB-1:0] ker;
        logic                              last;
    } beat_t;

    typedef img_t [DEPTH_NB-1:0] pixels_t;

    logic                              clk;
    logic                              rst;
    cfg_data_t                         cfg_data;
    cfg_addr_t                         cfg_addr;
    logic                              cfg_valid;
    ker_t [DEPTH_NB-1:0][GROUP_NB-1:0] kernel;
    logic                              kernel_rdy;
    img_t [GROUP_NB-1:0]               image;
    logic                              image_last;
    logic                              image_val;
    logic                              image_rdy;
    pixels_t                           result;
    logic                              result_val;
    logic                              result_rdy;

    integer     seed = 32'h092cf90d;
    layer_cfg_t cur_cfg;                // what the DUT was last told
    longint     win_max [DEPTH_NB];
    int         win_cnt;
    pixels_t    expected [$];
    beat_t      frame [$];

    layers #(
        .DEPTH_NB (DEPTH_NB),
        .GROUP_NB (GROUP_NB)
    ) u_layers (
        .clk        (clk),
        .rst        (rst),
        .cfg_data   (cfg_data),
        .cfg_addr   (cfg_addr),
        .cfg_valid  (cfg_valid),
        .kernel     (kernel),
        .kernel_rdy (kernel_rdy),
        .image      (image),
        .image_last (image_last),
        .image_val  (image_val),
        .image_rdy  (image_rdy),
        .result     (result),
        .result_val (result_val),
        .result_rdy (result_rdy)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_pixel(input img_t got, input img_t exp, input int lane);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at %0t ns: lane %0d result %0d, expected %0d",
                $time, lane, got, exp));
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at %0t ns: %s is %b, expected %b",
                $time, what, got, exp));
        end
    endtask

    function automatic int pick(input int lo, input int span);
        return lo + int'($unsigned($random(seed)) % span);
    endfunction

    // exact dot product of one lane over a whole frame
    function automatic longint dot(input beat_t beats [$], input int lane);
        longint acc;
        acc = 0;
        for (int k = 0; k < beats.size(); k++) begin
            for (int g = 0; g < GROUP_NB; g++) begin
                acc += longint'($signed(beats[k].img[g])) *
                       longint'($signed(beats[k].ker[lane][g]));
            end
        end
        return acc;
    endfunction

    function automatic img_t rescale(input longint acc);
        longint v;
        v = acc;
        if (!cur_cfg.bypass && v < 0) begin
            v = 0;
        end
        v = v >>> cur_cfg.shift;
        if (v > PIX_MAX) begin
            v = PIX_MAX;
        end else if (v < PIX_MIN) begin
            v = PIX_MIN;
        end
        return img_t'(v);
    endfunction

    // running max per lane, one expected result per finished window
    task automatic model_frame(input beat_t beats [$]);
        longint  s;
        pixels_t px;
        for (int d = 0; d < DEPTH_NB; d++) begin
            s = dot(beats, d);
            if (win_cnt == 0 || s > win_max[d]) begin
                win_max[d] = s;
            end
        end
        win_cnt++;
        if (win_cnt > int'(cur_cfg.pool_nb)) begin
            for (int d = 0; d < DEPTH_NB; d++) begin
                px[d] = rescale(win_max[d]);
            end
            expected.push_back(px);
            win_cnt = 0;
        end
    endtask

    task automatic make_frame(input int n, input int img_lo, input int img_span,
                              input int ker_lo, input int ker_span);
        beat_t b;
        frame.delete();
        for (int k = 0; k < n; k++) begin
            for (int g = 0; g < GROUP_NB; g++) begin
                b.img[g] = img_t'(pick(img_lo, img_span));
                for (int d = 0; d < DEPTH_NB; d++) begin
                    b.ker[d][g] = ker_t'(pick(ker_lo, ker_span));
                end
            end
            b.last = (k == n - 1);
            frame.push_back(b);
        end
    endtask

    task automatic write_cfg(input layer_cfg_t c);
        cfg_data  = {7'd0, c.bypass, c.pool_nb, c.shift, 8'd0};
        cfg_addr  = CFG_LAYERS;
        cfg_valid = 1'b1;
        @(posedge clk);
        #2;
        cfg_valid = 1'b0;
        cfg_addr  = '0;
        cur_cfg   = c;
        win_cnt   = 0;
    endtask

    task automatic send_frame(input beat_t beats [$]);
        int   k;
        logic took;
        logic took_d;
        model_frame(beats);
        k      = 0;
        took_d = 1'b0;
        while (k < beats.size()) begin
            image      = beats[k].img;
            image_last = beats[k].last;
            image_val  = 1'b1;
            @(negedge clk);
            check_level(kernel_rdy, took_d, "kernel_rdy");
            took = image_rdy;   // beat goes on the coming edge
            @(posedge clk);
            #2;
            if (took) begin
                kernel = beats[k].ker;
                k++;
            end
            took_d = took;
        end
        image_val  = 1'b0;
        image_last = 1'b0;
        @(negedge clk);
        check_level(kernel_rdy, 1'b1, "kernel_rdy");
        @(posedge clk);
        #2;
    endtask

    task automatic take_result(input int max_wait);
        pixels_t seen;
        pixels_t exp;
        int      waits;
        @(negedge clk);
        while (result_val !== 1'b1) begin
            @(negedge clk);
        end
        if (expected.size() == 0) begin
            abort_run("result_val rose although no result was expected");
        end
        seen  = result;
        waits = (max_wait > 0) ? pick(0, max_wait + 1) : 0;
        repeat (waits) begin
            @(negedge clk);
            check_level(result_val, 1'b1, "result_val");
            for (int d = 0; d < DEPTH_NB; d++) begin
                check_pixel(result[d], seen[d], d);
            end
        end
        @(posedge clk);
        #2;
        result_rdy = 1'b1;
        @(posedge clk);
        #2;
        result_rdy = 1'b0;
        exp = expected.pop_front();
        for (int d = 0; d < DEPTH_NB; d++) begin
            check_pixel(seen[d], exp[d], d);
        end
        @(negedge clk);
        check_level(result_val, 1'b0, "result_val");
        @(posedge clk);
        #2;
    endtask

    task automatic reset_levels();
        rst = 1'b1;
        repeat (9) @(posedge clk);
        @(negedge clk);
        check_level(image_rdy, 1'b0, "image_rdy");
        check_level(kernel_rdy, 1'b0, "kernel_rdy");
        check_level(result_val, 1'b0, "result_val");
        @(posedge clk);
        #2;
        rst = 1'b0;
        @(negedge clk);
        check_level(image_rdy, 1'b0, "image_rdy");
        @(negedge clk);
        check_level(image_rdy, 1'b0, "image_rdy");
        @(negedge clk);
        check_level(image_rdy, 1'b1, "image_rdy");  // two cycles after release
        @(posedge clk);
        #2;
    endtask

    task automatic relu_frames();
        write_cfg('{bypass: 1'b0, pool_nb: 8'd0, shift: 8'd0});
        make_frame(2, 0, 4, 0, 4);
        send_frame(frame);
        take_result(0);
        make_frame(2, 1, 3, -3, 3);     // strictly negative sums
        send_frame(frame);
        take_result(0);
    endtask

    task automatic bypass_and_shift();
        write_cfg('{bypass: 1'b1, pool_nb: 8'd0, shift: 8'd0});
        make_frame(2, 0, 4, -3, 4);
        send_frame(frame);
        take_result(0);
        write_cfg('{bypass: 1'b1, pool_nb: 8'd0, shift: 8'd2});
        make_frame(2, 0, 8, 0, 8);
        send_frame(frame);
        take_result(0);
        make_frame(4, 64, 64, 64, 64);  // well above 127 after shift
        send_frame(frame);
        take_result(0);
        make_frame(4, 64, 64, -128, 65);
        send_frame(frame);
        take_result(0);
    endtask

    task automatic pooled_window();
        write_cfg('{bypass: 1'b0, pool_nb: 8'd2, shift: 8'd1});
        make_frame(3, 0, 2, -2, 6);
        send_frame(frame);
        make_frame(3, 0, 6, -2, 6);
        send_frame(frame);
        make_frame(3, 0, 4, -2, 6);
        send_frame(frame);
        take_result(0);
    endtask

    task automatic stalled_results();
        write_cfg('{bypass: 1'b0, pool_nb: 8'd0, shift: 8'd1});
        fork
            begin
                repeat (4) begin
                    make_frame(3, 0, 8, -2, 8);
                    send_frame(frame);
                end
            end
            begin
                repeat (4) take_result(6);
            end
        join
    endtask

    initial begin
        rst        = 1'b1;
        cfg_data   = '0;
        cfg_addr   = '0;
        cfg_valid  = 1'b0;
        kernel     = '0;
        image      = '0;
        image_last = 1'b0;
        image_val  = 1'b0;
        result_rdy = 1'b0;
        cur_cfg    = '0;
        win_cnt    = 0;
        reset_levels();
        relu_frames();
        bypass_and_shift();
        pooled_window();
        stalled_results();
        if (expected.size() != 0) begin
            abort_run("results were lost, some expected values never came out");
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

    // watchdog
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        abort_run("timeout, the DUT stopped answering before the tests finished");
    end

endmodule

// File: bench/layers_props.sv
/*
 * Handshake and reset properties of the layers stage.
 * Bound into every layers instance, sampled on the rising clock edge.
 */
`timescale 1ns/1ps

module layers_props #(
    parameter int DEPTH_NB = 4
) (
    input logic                             clk,
    input logic                             rst,
    input logic                             image_val,
    input logic                             image_rdy,
    input logic                             kernel_rdy,
    input logic                             result_val,
    input logic                             result_rdy,
    input layers_pkg::img_t [DEPTH_NB-1:0]  result
);

    // result parked until the consumer takes it
    a_result_held: assert property (@(posedge clk) disable iff (rst)
        result_val && !result_rdy |=> result_val && $stable(result))
        else $error("result_val or result moved before result_rdy");

    a_kernel_follows: assert property (@(posedge clk) disable iff (rst)
        kernel_rdy == $past(image_val && image_rdy))
        else $error("kernel_rdy is not one cycle after the accepted beat");

    a_reset_quiet: assert property (@(posedge clk)
        rst |=> !image_rdy && !kernel_rdy && !result_val)
        else $error("handshake output high in the cycle after reset");

endmodule

bind layers layers_props #(
    .DEPTH_NB (DEPTH_NB)
) u_props (
    .clk        (clk),
    .rst        (rst),
    .image_val  (image_val),
    .image_rdy  (image_rdy),
    .kernel_rdy (kernel_rdy),
    .result_val (result_val),
    .result_rdy (result_rdy),
    .result     (result)
);

// File: verilog/layers.sv
/*
 * One convolution layer stage with DEPTH_NB output lanes.
 * The kernel slice must be valid while kernel_rdy is high.
 * result holds from result_val until a cycle with result_rdy high.
 */
`timescale 1ns/1ps

module layers #(
    parameter int DEPTH_NB = 4,
    parameter int GROUP_NB = 4
) (
    input  logic                                           clk,
    input  logic                                           rst,
    input  layers_pkg::cfg_data_t                          cfg_data,
    input  layers_pkg::cfg_addr_t                          cfg_addr,
    input  logic                                           cfg_valid,
    input  layers_pkg::ker_t [DEPTH_NB-1:0][GROUP_NB-1:0]  kernel,
    output logic                                           kernel_rdy,
    input  layers_pkg::img_t [GROUP_NB-1:0]                image,
    input  logic                                           image_last,
    input  logic                                           image_val,
    output logic                                           image_rdy,
    output layers_pkg::img_t [DEPTH_NB-1:0]                result,
    output logic                                           result_val,
    input  logic                                           result_rdy
);

    import layers_pkg::*;

    layer_cfg_t             cfg;
    lane_ctrl_t             ctrl;
    img_t [GROUP_NB-1:0]    image_1p;   // lines up with kernel_rdy
    img_t [DEPTH_NB-1:0]    pixels;

    layer_ctrl #(
        .GROUP_NB (GROUP_NB)
    ) u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .cfg_data   (cfg_data),
        .cfg_addr   (cfg_addr),
        .cfg_valid  (cfg_valid),
        .image_val  (image_val),
        .image_last (image_last),
        .result_rdy (result_rdy),
        .image_rdy  (image_rdy),
        .kernel_rdy (kernel_rdy),
        .result_val (result_val),
        .cfg        (cfg),
        .ctrl       (ctrl)
    );

    always_ff @(posedge clk) begin
        image_1p <= image;
    end

    for (genvar i = 0; i < DEPTH_NB; i++) begin : g_lane
        num_t [GROUP_NB-1:0] sums;
        num_t [GROUP_NB-1:0] hold;  // frozen frame sums
        num_t                total;
        num_t                pooled;

        group_mac #(.GROUP_NB(GROUP_NB)) u_mac (
            .clk  (clk),
            .rst  (rst),
            .img  (image_1p),
            .ker  (kernel[i]),
            .ctrl (ctrl),
            .sums (sums)
        );

        // next frame may accumulate while this one drains
        always_ff @(posedge clk) begin
            if (ctrl.hold_load) begin
                hold <= sums;
            end
        end

        group_add #(.GROUP_NB(GROUP_NB)) u_add (
            .clk   (clk),
            .parts (hold),
            .total (total)
        );

        pool u_pool (
            .clk    (clk),
            .ctrl   (ctrl),
            .value  (total),
            .pooled (pooled)
        );

        rectify_rescale u_rescale (
            .clk   (clk),
            .cfg   (cfg),
            .value (pooled),
            .pixel (pixels[i])
        );
    end

    always_ff @(posedge clk) begin
        if (ctrl.result_load) begin
            result <= pixels;
        end
    end

endmodule

// File: verilog/layer_ctrl.sv
/*
 * Configuration register and the two handshake state machines of the stage.
 * GROUP_NB must be a power of two and at least 2.
 * Write the configuration only while no frame is in flight.
 */
`timescale 1ns/1ps

module layer_ctrl #(
    parameter int GROUP_NB = 4
) (
    input  logic                    clk,
    input  logic                    rst,
    input  layers_pkg::cfg_data_t   cfg_data,
    input  layers_pkg::cfg_addr_t   cfg_addr,
    input  logic                    cfg_valid,
    input  logic                    image_val,
    input  logic                    image_last,
    input  logic                    result_rdy,
    output logic                    image_rdy,
    output logic                    kernel_rdy,
    output logic                    result_val,
    output layers_pkg::layer_cfg_t  cfg,
    output layers_pkg::lane_ctrl_t  ctrl
);

    import layers_pkg::*;

    localparam int MAC_LAT = 3;                 // accept to settled sums
    localparam int ADD_LAT = $clog2(GROUP_NB);  // tree depth
    localparam int OPS_LAT = 3;                 // pool plus rectify_rescale

    up_state_t up_state;
    up_state_t up_next;
    dn_state_t dn_state;
    dn_state_t dn_next;

    logic               accept;
    logic               mac_done;
    logic               add_start;
    logic               add_valid;
    logic               last_frame;
    logic [7:0]         pool_cnt;
    logic [MAC_LAT-1:0] last_sr;
    logic [ADD_LAT:0]   add_sr;
    logic [OPS_LAT-1:0] ops_sr;

    assign accept     = image_val && image_rdy;
    assign mac_done   = last_sr[MAC_LAT-1];
    assign add_start  = (up_state == UP_CLEAR) && (dn_state == DN_READY);
    assign add_valid  = add_sr[ADD_LAT];
    assign last_frame = (pool_cnt >= cfg.pool_nb);

    always_ff @(posedge clk) begin
        if (rst) begin
            cfg <= '0;
        end else if (cfg_valid && (cfg_addr == CFG_LAYERS)) begin
            cfg.bypass  <= cfg_data[24];
            cfg.pool_nb <= cfg_data[23:16];
            cfg.shift   <= cfg_data[15:8];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            up_state <= UP_RESET;
            dn_state <= DN_RESET;
        end else begin
            up_state <= up_next;
            dn_state <= dn_next;
        end
    end

    always_comb begin
        up_next = up_state;
        case (up_state)
            UP_RESET: begin
                if (dn_state != DN_RESET) begin    // down side out of reset first
                    up_next = UP_READY;
                end
            end
            UP_READY: begin
                if (accept && image_last) begin
                    up_next = UP_DONE;
                end
            end
            UP_DONE: begin
                if (mac_done) begin
                    up_next = UP_CLEAR;
                end
            end
            UP_CLEAR: begin
                if (dn_state == DN_READY) begin
                    up_next = UP_RESET;
                end
            end
            default: up_next = UP_RESET;
        endcase
    end

    always_comb begin
        dn_next = dn_state;
        case (dn_state)
            DN_RESET: dn_next = DN_READY;
            DN_READY: begin
                if (up_state == UP_CLEAR) begin
                    dn_next = DN_ADD;
                end
            end
            DN_ADD: begin
                if (add_valid) begin
                    dn_next = DN_POOL;
                end
            end
            DN_POOL: dn_next = last_frame ? DN_OPS : DN_READY;
            DN_OPS: begin
                if (ctrl.result_load) begin
                    dn_next = DN_CLEAR;
                end
            end
            DN_CLEAR: begin
                if (result_rdy) begin
                    dn_next = DN_RESET;
                end
            end
            default: dn_next = DN_RESET;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            kernel_rdy <= 1'b0;
            last_sr    <= '0;
            add_sr     <= '0;
            ops_sr     <= '0;
        end else begin
            kernel_rdy <= accept;
            last_sr    <= {last_sr[MAC_LAT-2:0], accept && image_last};
            add_sr     <= {add_sr[ADD_LAT-1:0], add_start};
            ops_sr     <= {ops_sr[OPS_LAT-2:0], (dn_state == DN_POOL) && last_frame};
        end
    end

    // frames seen in the current window
    always_ff @(posedge clk) begin
        if (rst || dn_state == DN_RESET) begin
            pool_cnt <= '0;
        end else if (dn_state == DN_POOL) begin
            pool_cnt <= pool_cnt + 8'd1;
        end
    end

    // lane controls leave from flops, they fan out to every lane
    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl <= '0;
        end else begin
            ctrl.mac_clr     <= (up_state == UP_RESET);
            ctrl.mac_en      <= accept;     // copy of kernel_rdy
            ctrl.hold_load   <= (up_state == UP_DONE) && mac_done;
            ctrl.pool_clr    <= (dn_state == DN_RESET);
            ctrl.pool_en     <= (dn_state == DN_POOL);
            ctrl.result_load <= ops_sr[OPS_LAT-1];
        end
    end

    assign image_rdy  = (up_state == UP_READY);
    assign result_val = (dn_state == DN_CLEAR);

endmodule

// File: verilog/rectify_rescale.sv
/*
 * ReLU with bypass, then arithmetic right shift and signed saturation.
 * Two cycles of latency. cfg must not change while a value is in flight.
 */
`timescale 1ns/1ps

module rectify_rescale (
    input  logic                    clk,
    input  layers_pkg::layer_cfg_t  cfg,
    input  layers_pkg::num_t        value,
    output layers_pkg::img_t        pixel
);

    import layers_pkg::*;

    localparam num_t PIX_MAX = num_t'(2 ** (IMG_WIDTH - 1) - 1);
    localparam num_t PIX_MIN = num_t'(-(2 ** (IMG_WIDTH - 1)));

    num_t rect;
    num_t shifted;

    always_ff @(posedge clk) begin
        if (!cfg.bypass && value[NUM_WIDTH-1]) begin
            rect <= '0;     // negative clipped
        end else begin
            rect <= value;
        end
    end

    assign shifted = rect >>> cfg.shift;

    always_ff @(posedge clk) begin
        if (shifted > PIX_MAX) begin
            pixel <= img_t'(PIX_MAX);
        end else if (shifted < PIX_MIN) begin
            pixel <= img_t'(PIX_MIN);
        end else begin
            pixel <= img_t'(shifted);
        end
    end

endmodule

// File: verilog/pool.sv
/*
 * Running signed maximum for one lane.
 * pool_clr arms the register so the next pool_en loads unconditionally.
 * pool_clr and pool_en are never high together.
 */
`timescale 1ns/1ps

module pool (
    input  logic                    clk,
    input  layers_pkg::lane_ctrl_t  ctrl,
    input  layers_pkg::num_t        value,
    output layers_pkg::num_t        pooled
);

    logic armed;    // window empty

    always_ff @(posedge clk) begin
        if (ctrl.pool_clr) begin
            armed <= 1'b1;
        end else if (ctrl.pool_en) begin
            armed <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.pool_en && (armed || value > pooled)) begin
            pooled <= value;
        end
    end

endmodule

// File: verilog/group_add.sv
/*
 * Registered binary adder tree over one lane's partial sums.
 * GROUP_NB must be a power of two, latency is clog2(GROUP_NB) cycles.
 * parts must stay steady for the first stage to sample them.
 */
`timescale 1ns/1ps

module group_add #(
    parameter int GROUP_NB = 4
) (
    input  logic                               clk,
    input  layers_pkg::num_t   [GROUP_NB-1:0]  parts,
    output layers_pkg::num_t                   total
);

    import layers_pkg::*;

    // heap order, node 1 is the root and leaves start at GROUP_NB
    num_t node [1:2*GROUP_NB-1];

    genvar k;
    generate
        for (k = 0; k < GROUP_NB; k++) begin : g_leaf
            assign node[GROUP_NB+k] = parts[k];
        end

        for (k = 1; k < GROUP_NB; k++) begin : g_node
            always_ff @(posedge clk) begin
                node[k] <= node[2*k] + node[2*k+1];
            end
        end
    endgenerate

    assign total = node[1];

endmodule

// File: verilog/group_mac.sv
/*
 * GROUP_NB multiply-accumulate units for one output lane.
 * img and ker are sampled in the cycle mac_en is high.
 * Products are registered, so the accumulate happens one cycle later.
 */
`timescale 1ns/1ps

module group_mac #(
    parameter int GROUP_NB = 4
) (
    input  logic                               clk,
    input  logic                               rst,
    input  layers_pkg::img_t   [GROUP_NB-1:0]  img,
    input  layers_pkg::ker_t   [GROUP_NB-1:0]  ker,
    input  layers_pkg::lane_ctrl_t             ctrl,
    output layers_pkg::num_t   [GROUP_NB-1:0]  sums
);

    import layers_pkg::*;

    num_t [GROUP_NB-1:0] prod;
    logic                mac_en_d;  // lines up with prod

    always_ff @(posedge clk) begin
        if (rst) begin
            mac_en_d <= 1'b0;
        end else begin
            mac_en_d <= ctrl.mac_en;
        end
    end

    // operands sign extend to the accumulator width
    always_ff @(posedge clk) begin
        for (int g = 0; g < GROUP_NB; g++) begin
            prod[g] <= $signed(img[g]) * $signed(ker[g]);
        end
    end

    always_ff @(posedge clk) begin
        for (int g = 0; g < GROUP_NB; g++) begin
            if (ctrl.mac_clr) begin
                sums[g] <= '0;
            end else if (mac_en_d) begin
                sums[g] <= sums[g] + prod[g];
            end
        end
    end

endmodule

// File: verilog/layers_pkg.sv
/*
 * Widths, types and control words shared by the convolution layer stage.
 * Accumulators wrap if a frame sum needs more than NUM_WIDTH bits.
 * The stage answers only to configuration address CFG_LAYERS.
 */
package layers_pkg;

    localparam int IMG_WIDTH = 8;   // signed pixel
    localparam int KER_WIDTH = 8;   // signed kernel weight
    localparam int NUM_WIDTH = 24;  // headroom for long frames

    typedef logic signed [IMG_WIDTH-1:0] img_t;
    typedef logic signed [KER_WIDTH-1:0] ker_t;
    typedef logic signed [NUM_WIDTH-1:0] num_t;

    localparam int CFG_DWIDTH = 32;
    localparam int CFG_AWIDTH = 5;

    typedef logic [CFG_DWIDTH-1:0] cfg_data_t;
    typedef logic [CFG_AWIDTH-1:0] cfg_addr_t;

    localparam cfg_addr_t CFG_LAYERS = 5'd3;

    typedef struct packed {
        logic       bypass;     // cfg_data[24], skips relu
        logic [7:0] pool_nb;    // cfg_data[23:16], frames per window minus one
        logic [7:0] shift;      // cfg_data[15:8]
    } layer_cfg_t;

    typedef struct packed {
        logic mac_clr;      // zero accumulators
        logic mac_en;       // beat in flight
        logic hold_load;    // frame sums to hold regs
        logic pool_clr;     // new pooling window
        logic pool_en;      // compare add result
        logic result_load;  // capture rescaled pixel
    } lane_ctrl_t;

    typedef enum logic [1:0] {UP_RESET, UP_READY, UP_DONE, UP_CLEAR} up_state_t;

    typedef enum logic [2:0] {
        DN_RESET, DN_READY, DN_ADD, DN_POOL, DN_OPS, DN_CLEAR
    } dn_state_t;

endpackage
